// File: rtl/fir_pkg.sv
package fir_pkg;

    // datapath sizes
    localparam int DATA_W   = 32;  // samples, coefficients, results
    localparam int ADDR_W   = 12;  // axi-lite byte address
    localparam int NUM_TAPS = 11;  // taps == history depth
    localparam int IDX_W    = 4;   // tap / history index

    // axi-lite register map (byte offsets)
    localparam logic [ADDR_W-1:0] REG_AP_CTRL  = 12'h000;
    localparam logic [ADDR_W-1:0] REG_DATA_LEN = 12'h010;
    localparam logic [ADDR_W-1:0] REG_TAP_BASE = 12'h080;  // tap i at base + 4*i

    // ap_ctrl bit positions
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT  = 1;
    localparam int AP_IDLE_BIT  = 2;

    // one committed axi-lite write
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } axil_wr_t;

    // one beat on the output stream
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;  // final beat of the run
    } stream_beat_t;

    // register block -> engine
    typedef struct packed {
        logic              start;     // single cycle kick
        logic [DATA_W-1:0] data_len;  // samples per run
    } eng_cfg_t;

    // register block run state
    typedef enum logic [1:0] {
        AP_IDLE = 2'd0,
        AP_BUSY = 2'd1,
        AP_DONE = 2'd2
    } ap_state_t;

endpackage

// File: rtl/fir_sram.sv
`timescale 1ns/1ps

// single port ram, synchronous read, no reset on contents
module fir_sram #(
    parameter int DEPTH = 11
) (
    input  logic                       axis_clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [fir_pkg::IDX_W-1:0]  addr,
    input  logic [fir_pkg::DATA_W-1:0] wdata,
    output logic [fir_pkg::DATA_W-1:0] rdata
);

    logic [fir_pkg::DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge axis_clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];  // old word on a write cycle
        end
    end

endmodule

// File: rtl/fir_ctrl_regs.sv
`timescale 1ns/1ps

module fir_ctrl_regs (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    // axi-lite write
    input  logic                        awvalid,
    input  logic                        wvalid,
    output logic                        awready,
    output logic                        wready,
    input  logic [fir_pkg::ADDR_W-1:0]  awaddr,
    input  logic [fir_pkg::DATA_W-1:0]  wdata,
    // axi-lite read
    input  logic                        arvalid,
    input  logic [fir_pkg::ADDR_W-1:0]  araddr,
    output logic                        arready,
    output logic                        rvalid,
    output logic [fir_pkg::DATA_W-1:0]  rdata,
    input  logic                        rready,
    // engine side
    output fir_pkg::eng_cfg_t           cfg,
    input  logic                        done,
    input  logic [fir_pkg::IDX_W-1:0]   tap_idx,
    output logic [fir_pkg::DATA_W-1:0]  tap_word
);

    fir_pkg::axil_wr_t          wr;
    fir_pkg::ap_state_t         state;
    logic                       wr_ack, ar_ack, rvalid_q;
    logic                       rd_start;
    logic                       is_idle, is_busy;
    logic                       start_pulse;
    logic                       tap_wr, tap_rd;
    logic                       rd_tap_q;         // current read targets tap ram
    logic [fir_pkg::DATA_W-1:0] rd_reg_q;         // ap_ctrl / len / zero
    logic [fir_pkg::DATA_W-1:0] tap_hold;         // tap word kept for rvalid
    logic [fir_pkg::DATA_W-1:0] data_len_q;
    logic [fir_pkg::DATA_W-1:0] ap_word;
    logic [fir_pkg::DATA_W-1:0] tap_rdata;
    logic [fir_pkg::IDX_W-1:0]  tap_addr;
    logic                       tap_en;

    // tap window check, word aligned
    function automatic logic is_tap_addr(input logic [fir_pkg::ADDR_W-1:0] a);
        return (a >= fir_pkg::REG_TAP_BASE) &&
               (a < fir_pkg::REG_TAP_BASE + 4 * fir_pkg::NUM_TAPS) &&
               (a[1:0] == 2'b00);
    endfunction

    function automatic logic [fir_pkg::IDX_W-1:0] tap_index(
        input logic [fir_pkg::ADDR_W-1:0] a
    );
        logic [fir_pkg::ADDR_W-1:0] off;
        off = a - fir_pkg::REG_TAP_BASE;
        return off[fir_pkg::IDX_W+1:2];  // byte -> word
    endfunction

    assign wr      = '{addr: awaddr, data: wdata};
    assign is_idle = state == fir_pkg::AP_IDLE;
    assign is_busy = state == fir_pkg::AP_BUSY;

    // write commits on the ack cycle
    assign awready     = wr_ack;
    assign wready      = wr_ack;
    assign start_pulse = wr_ack && is_idle && (wr.addr == fir_pkg::REG_AP_CTRL) &&
                         wr.data[fir_pkg::AP_START_BIT];
    assign tap_wr      = wr_ack && is_idle && is_tap_addr(wr.addr);

    // read starts once per transaction; a tap write owns the ram that cycle
    assign rd_start = arvalid && !ar_ack && !rvalid_q && !tap_wr;
    assign tap_rd   = rd_start && is_idle && is_tap_addr(araddr);
    assign arready  = ar_ack;
    assign rvalid   = rvalid_q;

    // start reads back as busy
    always_comb begin
        ap_word = '0;
        ap_word[fir_pkg::AP_START_BIT] = is_busy;
        ap_word[fir_pkg::AP_DONE_BIT]  = state == fir_pkg::AP_DONE;
        ap_word[fir_pkg::AP_IDLE_BIT]  = is_idle;
    end

    // tap ram: bus while idle, engine while busy
    assign tap_en   = is_busy || tap_wr || tap_rd;
    assign tap_addr = is_busy ? tap_idx :
                      tap_wr  ? tap_index(wr.addr) : tap_index(araddr);

    fir_sram #(.DEPTH(fir_pkg::NUM_TAPS)) u_tap_ram (
        .axis_clk (axis_clk),
        .en       (tap_en),
        .we       (tap_wr),
        .addr     (tap_addr),
        .wdata    (wr.data),
        .rdata    (tap_rdata)
    );

    assign tap_word = tap_rdata;
    assign cfg      = '{start: start_pulse, data_len: data_len_q};

    // handshakes, state, length
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ack     <= 1'b0;
            ar_ack     <= 1'b0;
            rvalid_q   <= 1'b0;
            rd_tap_q   <= 1'b0;
            data_len_q <= '0;
            state      <= fir_pkg::AP_IDLE;
        end else begin
            wr_ack <= awvalid && wvalid && !wr_ack;  // one cycle pulse
            ar_ack <= rd_start;
            if (rd_start) begin
                rvalid_q <= 1'b1;
                rd_tap_q <= tap_rd;
            end else if (rvalid_q && rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_ack && !is_busy && wr.addr == fir_pkg::REG_DATA_LEN) begin
                data_len_q <= wr.data;
            end
            case (state)
                fir_pkg::AP_IDLE: if (start_pulse) state <= fir_pkg::AP_BUSY;
                fir_pkg::AP_BUSY: if (done) state <= fir_pkg::AP_DONE;
                fir_pkg::AP_DONE: begin
                    // reading ap_ctrl acknowledges done
                    if (rd_start && araddr == fir_pkg::REG_AP_CTRL) state <= fir_pkg::AP_IDLE;
                end
                default: state <= fir_pkg::AP_IDLE;
            endcase
        end
    end

    // read data capture
    always_ff @(posedge axis_clk) begin
        if (rd_start) begin
            case (araddr)
                fir_pkg::REG_AP_CTRL:  rd_reg_q <= ap_word;   // value before done clears
                fir_pkg::REG_DATA_LEN: rd_reg_q <= data_len_q;
                default:               rd_reg_q <= '0;        // unmapped, or tap when not idle
            endcase
        end
        if (ar_ack && rd_tap_q) begin
            tap_hold <= tap_rdata;
        end
    end

    // tap word straight from ram on the first rvalid cycle
    assign rdata = !rd_tap_q ? rd_reg_q :
                   ar_ack    ? tap_rdata : tap_hold;

endmodule

// File: rtl/fir_engine.sv
`timescale 1ns/1ps

module fir_engine (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  fir_pkg::eng_cfg_t           cfg,
    output logic                        done,
    // tap ram lives in the register block
    output logic [fir_pkg::IDX_W-1:0]   tap_idx,
    input  logic [fir_pkg::DATA_W-1:0]  tap_word,
    // sample in
    input  logic                        ss_tvalid,
    input  logic [fir_pkg::DATA_W-1:0]  ss_tdata,
    output logic                        ss_tready,
    // result out
    output logic                        sm_tvalid,
    output logic [fir_pkg::DATA_W-1:0]  sm_tdata,
    output logic                        sm_tlast,
    input  logic                        sm_tready
);

    typedef enum logic [2:0] {
        ENG_IDLE,   // waiting for start
        ENG_CLEAR,  // zeroing history
        ENG_WAIT,   // ss_tready high
        ENG_CALC,   // walking the taps
        ENG_DRAIN   // pipeline tail + output hold
    } eng_state_t;

    eng_state_t                 state;
    logic [fir_pkg::IDX_W-1:0]  idx;        // clear addr or tap k
    logic [fir_pkg::IDX_W-1:0]  wr_ptr;     // slot of newest sample
    logic [fir_pkg::IDX_W-1:0]  rd_addr;
    logic [fir_pkg::IDX_W-1:0]  hist_addr;
    logic                       idx_last;
    logic                       in_fire, out_fire;
    logic                       clearing, calc;
    logic                       hist_en, hist_we;
    logic [fir_pkg::DATA_W-1:0] hist_wdata, hist_rdata;
    logic                       rd_vld, rd_last;    // ram outputs valid
    logic                       mul_vld, mul_last;  // product valid
    logic [fir_pkg::DATA_W-1:0] prod, acc;
    logic [fir_pkg::DATA_W-1:0] out_cnt;            // accepted outputs this run
    fir_pkg::stream_beat_t      out_beat;

    assign clearing = state == ENG_CLEAR;
    assign calc     = state == ENG_CALC;
    assign idx_last = idx == fir_pkg::IDX_W'(fir_pkg::NUM_TAPS - 1);

    assign ss_tready = state == ENG_WAIT;
    assign in_fire   = ss_tvalid && ss_tready;
    assign out_fire  = sm_tvalid && sm_tready;
    assign done      = out_fire && out_beat.last;  // last beat taken
    assign tap_idx   = idx;

    // x[n-k] sits k slots back from the write pointer with wraparound
    always_comb begin
        if (wr_ptr >= idx) begin
            rd_addr = wr_ptr - idx;
        end else begin
            rd_addr = wr_ptr + fir_pkg::IDX_W'(fir_pkg::NUM_TAPS) - idx;
        end
    end

    assign hist_we    = clearing || in_fire;
    assign hist_en    = hist_we || calc;
    assign hist_addr  = clearing ? idx : (in_fire ? wr_ptr : rd_addr);
    assign hist_wdata = clearing ? '0 : ss_tdata;

    fir_sram #(.DEPTH(fir_pkg::NUM_TAPS)) u_hist_ram (
        .axis_clk (axis_clk),
        .en       (hist_en),
        .we       (hist_we),
        .addr     (hist_addr),
        .wdata    (hist_wdata),
        .rdata    (hist_rdata)
    );

    // sequencing
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= ENG_IDLE;
            idx    <= '0;
            wr_ptr <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (cfg.start) begin
                        state  <= ENG_CLEAR;
                        idx    <= '0;
                        wr_ptr <= '0;
                    end
                end
                ENG_CLEAR: begin
                    if (idx_last) state <= ENG_WAIT;  // NUM_TAPS zero writes done
                    else          idx   <= idx + 1'b1;
                end
                ENG_WAIT: begin
                    if (in_fire) begin
                        state <= ENG_CALC;
                        idx   <= '0;
                    end
                end
                ENG_CALC: begin
                    if (idx_last) begin
                        state <= ENG_DRAIN;
                        // next sample goes one slot on
                        wr_ptr <= (wr_ptr == fir_pkg::IDX_W'(fir_pkg::NUM_TAPS - 1)) ?
                                  '0 : wr_ptr + 1'b1;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                ENG_DRAIN: begin
                    if (out_fire) state <= out_beat.last ? ENG_IDLE : ENG_WAIT;
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // pipeline valids, output valid and beat count
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_vld    <= 1'b0;
            rd_last   <= 1'b0;
            mul_vld   <= 1'b0;
            mul_last  <= 1'b0;
            sm_tvalid <= 1'b0;
            out_cnt   <= '0;
        end else begin
            rd_vld   <= calc;              // read stage
            rd_last  <= calc && idx_last;
            mul_vld  <= rd_vld;            // multiply stage
            mul_last <= rd_last;
            if (mul_last)      sm_tvalid <= 1'b1;  // sum complete
            else if (out_fire) sm_tvalid <= 1'b0;
            if (cfg.start)     out_cnt <= '0;
            else if (out_fire) out_cnt <= out_cnt + 1'b1;
        end
    end

    // mac datapath wraps mod 2^32
    always_ff @(posedge axis_clk) begin
        if (rd_vld) prod <= tap_word * hist_rdata;  // h[k] * x[n-k]
        if (in_fire) begin
            acc <= '0;
        end else if (mul_vld) begin
            acc <= acc + prod;
        end
        if (mul_last) begin
            out_beat.data <= acc + prod;  // final tap folded in
            out_beat.last <= out_cnt + 1'b1 == cfg.data_len;
        end
    end

    // beat held until accepted
    assign sm_tdata = out_beat.data;
    assign sm_tlast = out_beat.last;

endmodule

// File: rtl/fir_top.sv
`timescale 1ns/1ps

module fir_top (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    // axi-lite write
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [fir_pkg::ADDR_W-1:0]  awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [fir_pkg::DATA_W-1:0]  wdata,
    // axi-lite read
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [fir_pkg::ADDR_W-1:0]  araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [fir_pkg::DATA_W-1:0]  rdata,
    // axi-stream in, x[n]
    input  logic                        ss_tvalid,
    input  logic [fir_pkg::DATA_W-1:0]  ss_tdata,
    output logic                        ss_tready,
    // axi-stream out, y[n]
    output logic                        sm_tvalid,
    output logic [fir_pkg::DATA_W-1:0]  sm_tdata,
    output logic                        sm_tlast,
    input  logic                        sm_tready
);

    fir_pkg::eng_cfg_t          cfg;       // start + length
    logic                       done;      // last beat accepted
    logic [fir_pkg::IDX_W-1:0]  tap_idx;
    logic [fir_pkg::DATA_W-1:0] tap_word;  // h[tap_idx], one cycle late

    fir_ctrl_regs u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .awready    (awready),
        .wready     (wready),
        .awaddr     (awaddr),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rready     (rready),
        .cfg        (cfg),
        .done       (done),
        .tap_idx    (tap_idx),
        .tap_word   (tap_word)
    );

    fir_engine u_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .cfg        (cfg),
        .done       (done),
        .tap_idx    (tap_idx),
        .tap_word   (tap_word),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

endmodule

// File: testbench/fir_tb_tasks.svh
`ifndef FIR_TB_TASKS_SVH
`define FIR_TB_TASKS_SVH

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1, "mismatch on %s", what);
    end
endtask

function automatic logic [fir_pkg::ADDR_W-1:0] tap_addr(input int i);
    return fir_pkg::REG_TAP_BASE + fir_pkg::ADDR_W'(4 * i);  // 4 bytes per tap
endfunction

// y[n] = sum h[k] * x[n-k] mod 2^32
function automatic logic [31:0] fir_model(input int n);
    logic [31:0] sum;
    sum = '0;
    for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
        if (n - k >= 0) sum = sum + taps_ref[k] * x_ref[n - k];  // older samples are zero
    end
    return sum;
endfunction

// called and left on a falling edge
task automatic axil_write(input logic [fir_pkg::ADDR_W-1:0] addr, input logic [31:0] data);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge axis_clk);
    while (!awready) @(negedge axis_clk);
    check_value("wready with awready", wready, 1);
    @(negedge axis_clk);  // committed on the edge between
    awvalid = 1'b0;
    wvalid  = 1'b0;
endtask

task automatic read_check(input logic [fir_pkg::ADDR_W-1:0] addr, input logic [31:0] exp,
                          input string what);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge axis_clk);
    while (!rvalid) @(negedge axis_clk);
    check_value("arready as rvalid rises", arready, 1);
    check_value(what, rdata, exp);
    arvalid = 1'b0;
    @(negedge axis_clk);  // rvalid drops with rready high
    rready = 1'b0;
endtask

task automatic load_taps();
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
        taps_ref[i] = $random(seed);
        axil_write(tap_addr(i), taps_ref[i]);
    end
endtask

task automatic readback_taps();
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
        read_check(tap_addr(i), taps_ref[i], "tap readback");
    end
endtask

task automatic send_sample(input logic [31:0] x);
    ss_tdata  = x;
    ss_tvalid = 1'b1;
    while (!ss_tready) @(negedge axis_clk);
    @(negedge axis_clk);
    ss_tvalid = 1'b0;
endtask

task automatic take_output(input logic [31:0] exp, input logic exp_last, input int stall);
    logic [31:0] first;
    while (!sm_tvalid) @(negedge axis_clk);
    first = sm_tdata;
    repeat (stall) begin  // hold sm_tready low
        @(negedge axis_clk);
        check_value("sm_tvalid under back-pressure", sm_tvalid, 1);
        check_value("sm_tdata under back-pressure", sm_tdata, first);
        check_value("ss_tready while output pending", ss_tready, 0);
    end
    check_value("sm_tdata", sm_tdata, exp);
    check_value("sm_tlast", sm_tlast, exp_last);
    sm_tready = 1'b1;
    @(negedge axis_clk);
    sm_tready = 1'b0;
endtask

// one full run; poke tries tap writes while busy
task automatic run_filter(input int max_stall, input bit poke);
    int stall;
    axil_write(fir_pkg::REG_DATA_LEN, RUN_LEN);
    read_check(fir_pkg::REG_DATA_LEN, RUN_LEN, "data length");
    axil_write(fir_pkg::REG_AP_CTRL, 32'h1);
    if (poke) begin
        for (int i = 0; i < fir_pkg::NUM_TAPS; i++) axil_write(tap_addr(i), ~taps_ref[i]);
    end
    for (int n = 0; n < RUN_LEN; n++) begin
        x_ref[n] = $random(seed);
        send_sample(x_ref[n]);
        stall = (max_stall > 0) ? int'($unsigned($random(seed)) % (max_stall + 1)) : 0;
        take_output(fir_model(n), n == RUN_LEN - 1, stall);
    end
    read_check(fir_pkg::REG_AP_CTRL, 1 << fir_pkg::AP_DONE_BIT, "ap_ctrl after last beat");
    read_check(fir_pkg::REG_AP_CTRL, 1 << fir_pkg::AP_IDLE_BIT, "ap_ctrl after done read");
endtask

task automatic idle_after_reset();
    check_value("awready after reset", awready, 0);
    check_value("wready after reset", wready, 0);
    check_value("arready after reset", arready, 0);
    check_value("rvalid after reset", rvalid, 0);
    check_value("ss_tready after reset", ss_tready, 0);
    check_value("sm_tvalid after reset", sm_tvalid, 0);
    read_check(fir_pkg::REG_AP_CTRL, 1 << fir_pkg::AP_IDLE_BIT, "ap_ctrl after reset");
endtask

task automatic tap_bus_access();
    load_taps();
    readback_taps();
    read_check(12'h004, 0, "unmapped 0x004");
    read_check(12'h020, 0, "unmapped 0x020");
    read_check(12'h082, 0, "misaligned tap address");
    read_check(tap_addr(fir_pkg::NUM_TAPS), 0, "address past last tap");
    read_check(12'hffc, 0, "unmapped 0xffc");
endtask

// new taps, fresh history, busy writes dropped
task automatic restart_with_new_taps();
    load_taps();
    run_filter(0, 1'b1);
    readback_taps();
endtask

`endif

// File: testbench/fir_tb.sv
`timescale 1ns/1ps

module fir_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;
    localparam int RUN_LEN    = 20;  // samples per run
    localparam int MAX_STALL  = 7;   // longest output back-pressure
    localparam int NUM_RUNS   = 3;
    // intake, tap walk, pipeline tail, stall and handshakes per sample
    localparam int SAMPLE_CYCLES = fir_pkg::NUM_TAPS + MAX_STALL + 10;
    // tap loads, readbacks, busy pokes, status reads
    localparam int BUS_CYCLES = 6 * (4 * fir_pkg::NUM_TAPS + 30);
    localparam int WATCHDOG_CYCLES = 2 * (RST_CYCLES + BUS_CYCLES +
        NUM_RUNS * (fir_pkg::NUM_TAPS + RUN_LEN * SAMPLE_CYCLES));

    logic                        axis_clk;
    logic                        axis_rst_n;
    logic                        awvalid, awready, wvalid, wready;
    logic [fir_pkg::ADDR_W-1:0]  awaddr;
    logic [fir_pkg::DATA_W-1:0]  wdata;
    logic                        arvalid, arready, rvalid, rready;
    logic [fir_pkg::ADDR_W-1:0]  araddr;
    logic [fir_pkg::DATA_W-1:0]  rdata;
    logic                        ss_tvalid, ss_tready;
    logic [fir_pkg::DATA_W-1:0]  ss_tdata;
    logic                        sm_tvalid, sm_tready, sm_tlast;
    logic [fir_pkg::DATA_W-1:0]  sm_tdata;

    int                          seed;
    logic [fir_pkg::DATA_W-1:0]  taps_ref [fir_pkg::NUM_TAPS];  // h[k] as written
    logic [fir_pkg::DATA_W-1:0]  x_ref [RUN_LEN];               // samples of this run

    fir_top uut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    `include "fir_tb_tasks.svh"

    initial begin
        axis_clk = 1'b0;
        forever #(CLK_PERIOD / 2) axis_clk = ~axis_clk;
    end

    // stuck handshake guard
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed       = 32'ha42ff8ce;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        awaddr     = '0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (RST_CYCLES) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
        @(negedge axis_clk);
        idle_after_reset();
        tap_bus_access();
        run_filter(0, 1'b0);          // plain run with sm_tready answering at once
        run_filter(MAX_STALL, 1'b0);  // random back-pressure
        restart_with_new_taps();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+testbench
rtl/fir_pkg.sv
rtl/fir_sram.sv
rtl/fir_ctrl_regs.sv
rtl/fir_engine.sv
rtl/fir_top.sv
testbench/fir_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module fir_tb -f filelist.f -o fir_tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fir_tb_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "test run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "test run passed"
